/* list.f */
+incdir+tests
verilog/ps2Pkg.sv
verilog/ps2LineSync.sv
verilog/ps2FrameReceiver.sv
verilog/scanCodeDecoder.sv
verilog/asciiTranslator.sv
verilog/ps2Keyboard.sv
tests/ps2Keyboard_asserts.sv
tests/ps2KeyboardTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module ps2KeyboardTb -f list.f &&
./obj_dir/Vps2KeyboardTb | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" || { echo "FAIL"; exit 1; }

/* tests/asciiModel.svh */
// Reference model of the keyboard, stepped once per good frame sent.
logic [7:0] codeQ[$];             // Raw bytes still due on ps2Code.
logic [6:0] asciiQ[$];            // Characters still due on asciiCode.
logic mShiftL = 1'b0;
logic mShiftR = 1'b0;
logic mCtrlL = 1'b0;
logic mCtrlR = 1'b0;
logic mCaps = 1'b0;
logic mBreak = 1'b0;
logic mExtend = 1'b0;

// Keys a through z in scan code set 2.
logic [7:0] letterCodes[26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
	8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A,
	8'h1D, 8'h22, 8'h35, 8'h1A};
// Digit and punctuation keys with their plain, shifted and control characters.
// FF marks a key with no control character.
logic [7:0] symCodes[21] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E,
	8'h46, 8'h52, 8'h41, 8'h4E, 8'h49, 8'h4A, 8'h4C, 8'h55, 8'h54, 8'h5D, 8'h5B, 8'h0E};
logic [7:0] symPlain[21] = '{8'h30, 8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'h37, 8'h38,
	8'h39, 8'h27, 8'h2C, 8'h2D, 8'h2E, 8'h2F, 8'h3B, 8'h3D, 8'h5B, 8'h5C, 8'h5D, 8'h60};
logic [7:0] symShifted[21] = '{8'h29, 8'h21, 8'h40, 8'h23, 8'h24, 8'h25, 8'h5E, 8'h26, 8'h2A,
	8'h28, 8'h22, 8'h3C, 8'h5F, 8'h3E, 8'h3F, 8'h3A, 8'h2B, 8'h7B, 8'h7C, 8'h7D, 8'h7E};
logic [7:0] symCtrl[21] = '{8'hFF, 8'hFF, 8'h00, 8'hFF, 8'hFF, 8'hFF, 8'h1E, 8'hFF, 8'hFF,
	8'hFF, 8'hFF, 8'hFF, 8'h1F, 8'hFF, 8'h7F, 8'hFF, 8'hFF, 8'h1B, 8'h1C, 8'h1D, 8'hFF};

// Character for a make code, or -1 when the key has none.
function automatic int translateKey(input logic [7:0] code, input logic ext, input logic shift,
		input logic ctrl, input logic caps);
	int letter;
	int sym;
	letter = -1;
	sym = -1;
	foreach (letterCodes[i]) if (letterCodes[i] == code) letter = i;
	foreach (symCodes[i]) if (symCodes[i] == code) sym = i;
	if (ext) return (code == 8'h71) ? 'h7F : -1;       // Delete only.
	if (ctrl && letter >= 0) return letter + 1;
	if (ctrl) return (sym >= 0 && symCtrl[sym] != 8'hFF) ? int'(symCtrl[sym]) : -1;
	case (code)
		8'h29: return 'h20;
		8'h66: return 'h08;
		8'h0D: return 'h09;
		8'h5A: return 'h0D;
		8'h76: return 'h1B;
		default: ;
	endcase
	if (letter >= 0) return (shift != caps ? 'h41 : 'h61) + letter;
	if (sym >= 0) return shift ? int'(symShifted[sym]) : int'(symPlain[sym]);
	return -1;
endfunction

// Prefixes, modifiers, then the character if the byte ends a make sequence.
function automatic void modelByte(input logic [7:0] b);
	int ch;
	codeQ.push_back(b);
	ch = translateKey(b, mExtend, mShiftL || mShiftR, mCtrlL || mCtrlR, mCaps);
	if (b == CODE_BREAK) begin
		mBreak = 1'b1;
	end else if (b == CODE_EXTEND) begin
		mExtend = 1'b1;
	end else begin
		if (b == CODE_LSHIFT) mShiftL = !mBreak;
		else if (b == CODE_RSHIFT) mShiftR = !mBreak;
		else if (b == CODE_CTRL && mExtend) mCtrlR = !mBreak;
		else if (b == CODE_CTRL) mCtrlL = !mBreak;
		else if (b == CODE_CAPS) mCaps = mCaps ^ !mBreak;
		else if (!mBreak && ch >= 0) asciiQ.push_back(7'(ch));
		mBreak = 1'b0;
		mExtend = 1'b0;
	end
endfunction

/* tests/ps2KeyboardTb.sv */
module ps2KeyboardTb;
	import ps2Pkg::*;

	localparam int HALF_BIT = 20;                  // System cycles per keyboard clock phase.
	localparam int CYCLE_LIMIT = 60 * FRAME_BITS * 40 * 2;

	logic clk;
	logic rst;
	logic ps2Clk;
	logic ps2Data;
	logic [7:0] ps2Code;
	logic ps2CodeNew;
	logic frameError;
	logic [6:0] asciiCode;
	logic asciiNew;
	int errPending = 0;                            // Bad frames not flagged yet.
	int cycles = 0;

	`include "asciiModel.svh"

	ps2Keyboard uut (.*);

	bind ps2Keyboard ps2KeyboardAsserts asserts (.clk(clk), .rst(rst), .ps2CodeNew(ps2CodeNew),
		.frameError(frameError), .asciiNew(asciiNew));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [7:0] got, input logic [7:0] want);
		if (got !== want) failRun($sformatf("Fail %s: got %h, expected %h", name, got, want));
	endtask

	// Outputs are long settled at the falling edge.
	always @(negedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) failRun("Timeout, the tests ran past their cycle limit");
		if (!rst && ps2CodeNew) begin
			if (codeQ.size() == 0) failRun("Scan code strobe with no good frame sent");
			else checkValue("ps2Code", ps2Code, codeQ.pop_front());
		end
		if (!rst && asciiNew) begin
			if (asciiQ.size() == 0) failRun("Character strobe with no character expected");
			else checkValue("asciiCode", {1'b0, asciiCode}, {1'b0, asciiQ.pop_front()});
		end
		if (!rst && frameError) begin
			if (errPending == 0) failRun("Frame error strobe on a good frame");
			else errPending--;
		end
	end

	task automatic tick(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// One frame from the keyboard side, cut short when bitCnt < FRAME_BITS.
	task automatic sendFrame(input logic [7:0] data, input int bitCnt, input logic badParity,
			input logic badStop);
		logic [10:0] frame;
		frame = {!badStop, !(^data) ^ badParity, data, 1'b0};
		if (bitCnt == FRAME_BITS && !badParity && !badStop) modelByte(data);
		else if (bitCnt == FRAME_BITS) errPending++;
		for (int i = 0; i < bitCnt; i++) begin
			ps2Data = frame[i];                    // Data moves while the clock is high.
			tick(HALF_BIT);
			ps2Clk = 1'b0;
			tick(HALF_BIT);
			ps2Clk = 1'b1;
		end
		ps2Data = 1'b1;
		tick(HALF_BIT);
	endtask

	task automatic sendByte(input logic [7:0] data);
		sendFrame(data, FRAME_BITS, 1'b0, 1'b0);
	endtask

	task automatic tapKey(input logic [7:0] code);
		sendByte(code);
		sendByte(CODE_BREAK);
		sendByte(code);
	endtask

	task automatic releaseModifiers();
		logic [7:0] seq[9];
		seq = '{CODE_BREAK, CODE_LSHIFT, CODE_BREAK, CODE_RSHIFT, CODE_BREAK, CODE_CTRL,
			CODE_EXTEND, CODE_BREAK, CODE_CTRL};
		foreach (seq[i]) sendByte(seq[i]);
	endtask

	function automatic logic [7:0] randomKey();
		int idx;
		idx = $urandom % 47;
		return (idx < 26) ? letterCodes[idx] : symCodes[idx - 26];
	endfunction

	initial begin
		void'($urandom(51));
		rst = 1'b1;
		ps2Clk = 1'b1;
		ps2Data = 1'b1;
		tick(10);
		rst = 1'b0;
		tick(10);

		repeat (10) sendByte(8'($urandom));      // Any byte value on the raw path.
		releaseModifiers();

		// Plain keys, shifted keys, caps lock alone and with shift.
		repeat (4) tapKey(randomKey());
		sendByte(CODE_LSHIFT);
		repeat (2) tapKey(randomKey());
		sendByte(CODE_BREAK);
		sendByte(CODE_LSHIFT);
		tapKey(CODE_CAPS);
		repeat (2) tapKey(randomKey());
		sendByte(CODE_RSHIFT);
		tapKey(letterCodes[$urandom % 26]);
		sendByte(CODE_BREAK);
		sendByte(CODE_RSHIFT);
		tapKey(CODE_CAPS);

		// Left control, right control, delete and an unmapped key.
		sendByte(CODE_CTRL);
		tapKey(letterCodes[$urandom % 26]);
		tapKey(8'h54);
		sendByte(CODE_BREAK);
		sendByte(CODE_CTRL);
		sendByte(CODE_EXTEND);
		sendByte(CODE_CTRL);
		tapKey(letterCodes[$urandom % 26]);
		sendByte(CODE_EXTEND);
		sendByte(CODE_BREAK);
		sendByte(CODE_CTRL);
		sendByte(CODE_EXTEND);
		sendByte(8'h71);
		sendByte(CODE_EXTEND);
		sendByte(CODE_BREAK);
		sendByte(8'h71);
		tapKey(8'h05);

		// Bad parity, bad stop, then a good frame.
		sendFrame(8'($urandom), FRAME_BITS, 1'b1, 1'b0);
		sendFrame(8'($urandom), FRAME_BITS, 1'b0, 1'b1);
		sendByte(randomKey());

		// Partial frames left to time out.
		repeat (2) begin
			sendFrame(8'($urandom), 1 + $urandom % 10, 1'b0, 1'b0);
			tick(FRAME_TIMEOUT + 100);
			sendByte(randomKey());
		end

		tick(100);
		if (codeQ.size() != 0 || asciiQ.size() != 0 || errPending != 0) begin
			failRun("Expected outputs never arrived");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

/* tests/ps2Keyboard_asserts.sv */
module ps2KeyboardAsserts (
	input logic clk,
	input logic rst,
	input logic ps2CodeNew,
	input logic frameError,
	input logic asciiNew
);

	// A frame is either good or bad.
	assert property (@(posedge clk) disable iff (rst) !(ps2CodeNew && frameError))
		else $error("ps2CodeNew and frameError high in the same cycle");

	// Decoder and translator each add one cycle.
	assert property (@(posedge clk) disable iff (rst) asciiNew |-> $past(ps2CodeNew, 2))
		else $error("asciiNew without ps2CodeNew two cycles before");

	assert property (@(posedge clk) rst && $past(rst) |-> !ps2CodeNew && !frameError && !asciiNew)
		else $error("Strobe high while in reset");

endmodule

/* verilog/asciiTranslator.sv */
module asciiTranslator (
	input logic clk,
	input logic rst,
	input ps2Pkg::keyEvent_t keyEvent,
	output logic [6:0] asciiCode,
	output logic asciiNew
);
	import ps2Pkg::*;

	logic letterHit;
	logic [4:0] letterIdx;        // 0 for a through 25 for z.
	logic plainHit;
	logic [6:0] plainChar;
	logic shiftHit;
	logic [6:0] shiftChar;
	logic mapped;
	logic [6:0] ch;

	// Letter keys.
	always_comb begin
		letterHit = 1'b1;
		case (keyEvent.code)
			8'h1C: letterIdx = 5'd0;
			8'h32: letterIdx = 5'd1;
			8'h21: letterIdx = 5'd2;
			8'h23: letterIdx = 5'd3;
			8'h24: letterIdx = 5'd4;
			8'h2B: letterIdx = 5'd5;
			8'h34: letterIdx = 5'd6;
			8'h33: letterIdx = 5'd7;
			8'h43: letterIdx = 5'd8;
			8'h3B: letterIdx = 5'd9;
			8'h42: letterIdx = 5'd10;
			8'h4B: letterIdx = 5'd11;
			8'h3A: letterIdx = 5'd12;
			8'h31: letterIdx = 5'd13;
			8'h44: letterIdx = 5'd14;
			8'h4D: letterIdx = 5'd15;
			8'h15: letterIdx = 5'd16;
			8'h2D: letterIdx = 5'd17;
			8'h1B: letterIdx = 5'd18;
			8'h2C: letterIdx = 5'd19;
			8'h3C: letterIdx = 5'd20;
			8'h2A: letterIdx = 5'd21;
			8'h1D: letterIdx = 5'd22;
			8'h22: letterIdx = 5'd23;
			8'h35: letterIdx = 5'd24;
			8'h1A: letterIdx = 5'd25;
			default: begin
				letterHit = 1'b0;
				letterIdx = '0;
			end
		endcase
	end

	// Digits and punctuation on the US layout without shift.
	always_comb begin
		plainHit = 1'b1;
		case (keyEvent.code)
			8'h45: plainChar = 7'h30;
			8'h16: plainChar = 7'h31;
			8'h1E: plainChar = 7'h32;
			8'h26: plainChar = 7'h33;
			8'h25: plainChar = 7'h34;
			8'h2E: plainChar = 7'h35;
			8'h36: plainChar = 7'h36;
			8'h3D: plainChar = 7'h37;
			8'h3E: plainChar = 7'h38;
			8'h46: plainChar = 7'h39;
			8'h52: plainChar = 7'h27;
			8'h41: plainChar = 7'h2C;
			8'h4E: plainChar = 7'h2D;
			8'h49: plainChar = 7'h2E;
			8'h4A: plainChar = 7'h2F;
			8'h4C: plainChar = 7'h3B;
			8'h55: plainChar = 7'h3D;
			8'h54: plainChar = 7'h5B;
			8'h5D: plainChar = 7'h5C;
			8'h5B: plainChar = 7'h5D;
			8'h0E: plainChar = 7'h60;
			default: begin
				plainHit = 1'b0;
				plainChar = '0;
			end
		endcase
	end

	// Same keys with shift held.
	always_comb begin
		shiftHit = 1'b1;
		case (keyEvent.code)
			8'h16: shiftChar = 7'h21;
			8'h52: shiftChar = 7'h22;
			8'h26: shiftChar = 7'h23;
			8'h25: shiftChar = 7'h24;
			8'h2E: shiftChar = 7'h25;
			8'h3D: shiftChar = 7'h26;
			8'h46: shiftChar = 7'h28;
			8'h45: shiftChar = 7'h29;
			8'h3E: shiftChar = 7'h2A;
			8'h55: shiftChar = 7'h2B;
			8'h4C: shiftChar = 7'h3A;
			8'h41: shiftChar = 7'h3C;
			8'h49: shiftChar = 7'h3E;
			8'h4A: shiftChar = 7'h3F;
			8'h1E: shiftChar = 7'h40;
			8'h36: shiftChar = 7'h5E;
			8'h4E: shiftChar = 7'h5F;
			8'h54: shiftChar = 7'h7B;
			8'h5D: shiftChar = 7'h7C;
			8'h5B: shiftChar = 7'h7D;
			8'h0E: shiftChar = 7'h7E;
			default: begin
				shiftHit = 1'b0;
				shiftChar = '0;
			end
		endcase
	end

	// Extended keys first, then control, whitespace keys, letters and symbols.
	always_comb begin
		mapped = 1'b1;
		ch = '0;
		if (keyEvent.extended) begin
			mapped = (keyEvent.code == 8'h71);  // Delete.
			ch = 7'h7F;
		end else if (keyEvent.ctrl) begin
			if (letterHit) begin
				ch = 7'(letterIdx) + 7'd1;
			end else begin
				case (keyEvent.code)
					8'h1E: ch = 7'h00;
					8'h54: ch = 7'h1B;
					8'h5D: ch = 7'h1C;
					8'h5B: ch = 7'h1D;
					8'h36: ch = 7'h1E;
					8'h4E: ch = 7'h1F;
					8'h4A: ch = 7'h7F;
					default: mapped = 1'b0;
				endcase
			end
		end else begin
			case (keyEvent.code)
				8'h29: ch = 7'h20;
				8'h66: ch = 7'h08;
				8'h0D: ch = 7'h09;
				8'h5A: ch = 7'h0D;
				8'h76: ch = 7'h1B;
				default: begin
					if (letterHit) begin
						// Shift and caps cancel each other.
						ch = (keyEvent.shift != keyEvent.caps ? 7'h41 : 7'h61) + 7'(letterIdx);
					end else if (keyEvent.shift) begin
						mapped = shiftHit;
						ch = shiftChar;
					end else begin
						mapped = plainHit;
						ch = plainChar;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			asciiNew <= 1'b0;
		end else begin
			asciiNew <= keyEvent.valid && mapped;
		end
	end

	always_ff @(posedge clk) begin
		if (keyEvent.valid && mapped) begin
			asciiCode <= ch;
		end
	end

endmodule

/* verilog/ps2FrameReceiver.sv */
module ps2FrameReceiver (
	input logic clk,
	input logic rst,
	input logic ps2Fall,
	input logic dataLevel,
	output ps2Pkg::scanCode_t rxCode,
	output logic frameError
);
	import ps2Pkg::*;

	rxState_t state;
	logic [7:0] shiftReg;
	logic [2:0] bitCount;
	logic parityOk;
	logic [TIMEOUT_W-1:0] idleCount;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RX_IDLE;
			bitCount <= '0;
			parityOk <= 1'b0;
			idleCount <= '0;
			rxCode <= '0;
			frameError <= 1'b0;
		end else begin
			rxCode.valid <= 1'b0;
			frameError <= 1'b0;

			// Counts cycles since the last keyboard clock edge.
			if (state == RX_IDLE || ps2Fall) begin
				idleCount <= '0;
			end else begin
				idleCount <= idleCount + 1'b1;
			end

			if (ps2Fall) begin
				case (state)
					RX_IDLE: begin
						if (dataLevel) begin
							frameError <= 1'b1;          // Bad start bit.
						end else begin
							state <= RX_DATA;
							bitCount <= '0;
						end
					end
					RX_DATA: begin
						bitCount <= bitCount + 1'b1;
						if (bitCount == DATA_LAST) begin
							state <= RX_PARITY;
						end
					end
					RX_PARITY: begin
						parityOk <= ^{dataLevel, shiftReg};   // Odd parity.
						state <= RX_STOP;
					end
					RX_STOP: begin
						state <= RX_IDLE;
						if (parityOk && dataLevel) begin
							rxCode.code <= shiftReg;
							rxCode.valid <= 1'b1;
						end else begin
							frameError <= 1'b1;
						end
					end
					default: state <= RX_IDLE;
				endcase
			end else if (state != RX_IDLE && idleCount == TIMEOUT_LAST) begin
				// Keyboard went quiet mid frame. Drop it silently.
				state <= RX_IDLE;
			end
		end
	end

	// Data bits arrive LSB first.
	always_ff @(posedge clk) begin
		if (ps2Fall && state == RX_DATA) begin
			shiftReg <= {dataLevel, shiftReg[7:1]};
		end
	end

endmodule

/* verilog/ps2Keyboard.sv */
module ps2Keyboard (
	input logic clk,
	input logic rst,
	input logic ps2Clk,
	input logic ps2Data,
	output logic [7:0] ps2Code,
	output logic ps2CodeNew,
	output logic frameError,
	output logic [6:0] asciiCode,
	output logic asciiNew
);
	import ps2Pkg::*;

	logic ps2Fall;
	logic dataLevel;
	scanCode_t rxCode;
	keyEvent_t keyEvent;

	ps2LineSync lineSync (
		.clk(clk),
		.rst(rst),
		.ps2Clk(ps2Clk),
		.ps2Data(ps2Data),
		.ps2Fall(ps2Fall),
		.dataLevel(dataLevel)
	);

	ps2FrameReceiver frameReceiver (
		.clk(clk),
		.rst(rst),
		.ps2Fall(ps2Fall),
		.dataLevel(dataLevel),
		.rxCode(rxCode),
		.frameError(frameError)
	);

	scanCodeDecoder decoder (
		.clk(clk),
		.rst(rst),
		.rxCode(rxCode),
		.keyEvent(keyEvent)
	);

	asciiTranslator translator (
		.clk(clk),
		.rst(rst),
		.keyEvent(keyEvent),
		.asciiCode(asciiCode),
		.asciiNew(asciiNew)
	);

	// Raw bytes go out as received, prefixes included.
	assign ps2Code = rxCode.code;
	assign ps2CodeNew = rxCode.valid;

endmodule

/* verilog/ps2LineSync.sv */
module ps2LineSync (
	input logic clk,
	input logic rst,
	input logic ps2Clk,
	input logic ps2Data,
	output logic ps2Fall,
	output logic dataLevel
);
	import ps2Pkg::*;

	// Bit 0 is the keyboard clock, bit 1 the data line.
	logic [1:0] syncA;
	logic [1:0] syncB;
	logic [1:0] level;
	logic [1:0][FILTER_CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			syncA <= '1;
			syncB <= '1;
			level <= '1;                          // Idle lines are high.
			count <= '0;
			ps2Fall <= 1'b0;
		end else begin
			syncA <= {ps2Data, ps2Clk};
			syncB <= syncA;
			for (int i = 0; i < 2; i++) begin
				if (syncB[i] == level[i]) begin
					count[i] <= '0;
				end else if (count[i] == FILTER_LAST) begin
					level[i] <= syncB[i];             // Held long enough, take it.
					count[i] <= '0;
				end else begin
					count[i] <= count[i] + 1'b1;
				end
			end
			// Pulse in the same cycle the filtered clock drops.
			ps2Fall <= level[0] && !syncB[0] && (count[0] == FILTER_LAST);
		end
	end

	assign dataLevel = level[1];

endmodule

/* verilog/ps2Pkg.sv */
package ps2Pkg;

	// Line filter.
	localparam int FILTER_LEN = 4;               // Stable samples before a level change.
	localparam int FILTER_CNT_W = $clog2(FILTER_LEN);
	localparam logic [FILTER_CNT_W-1:0] FILTER_LAST = FILTER_CNT_W'(FILTER_LEN - 1);

	// Frame of a start bit, 8 data bits, odd parity and a stop bit.
	localparam int FRAME_BITS = 11;
	localparam int DATA_BITS = FRAME_BITS - 3;
	localparam logic [2:0] DATA_LAST = 3'(DATA_BITS - 1);

	// Cycles without a keyboard clock edge before a partial frame is dropped.
	localparam int FRAME_TIMEOUT = 2000;
	localparam int TIMEOUT_W = $clog2(FRAME_TIMEOUT);
	localparam logic [TIMEOUT_W-1:0] TIMEOUT_LAST = TIMEOUT_W'(FRAME_TIMEOUT - 1);

	// Prefix bytes.
	localparam logic [7:0] CODE_BREAK = 8'hF0;
	localparam logic [7:0] CODE_EXTEND = 8'hE0;

	// Modifier keys in scan code set 2.
	localparam logic [7:0] CODE_LSHIFT = 8'h12;
	localparam logic [7:0] CODE_RSHIFT = 8'h59;
	localparam logic [7:0] CODE_CTRL = 8'h14;    // Right control carries the E0 prefix.
	localparam logic [7:0] CODE_CAPS = 8'h58;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rxState_t;

	// One received byte.
	typedef struct packed {
		logic [7:0] code;
		logic valid;
	} scanCode_t;

	// A make event with the modifier state at the time of the key.
	typedef struct packed {
		logic [7:0] code;
		logic extended;
		logic shift;      // Either shift held.
		logic ctrl;       // Either control held.
		logic caps;
		logic valid;
	} keyEvent_t;

endpackage

/* verilog/scanCodeDecoder.sv */
module scanCodeDecoder (
	input logic clk,
	input logic rst,
	input ps2Pkg::scanCode_t rxCode,
	output ps2Pkg::keyEvent_t keyEvent
);
	import ps2Pkg::*;

	logic breakPending;
	logic extendPending;
	logic shiftL;
	logic shiftR;
	logic ctrlL;
	logic ctrlR;
	logic capsOn;

	always_ff @(posedge clk) begin
		if (rst) begin
			breakPending <= 1'b0;
			extendPending <= 1'b0;
			shiftL <= 1'b0;
			shiftR <= 1'b0;
			ctrlL <= 1'b0;
			ctrlR <= 1'b0;
			capsOn <= 1'b0;
			keyEvent <= '0;
		end else begin
			keyEvent.valid <= 1'b0;
			if (rxCode.valid) begin
				case (rxCode.code)
					CODE_BREAK: breakPending <= 1'b1;
					CODE_EXTEND: extendPending <= 1'b1;
					default: begin
						// Final byte of a sequence.
						breakPending <= 1'b0;
						extendPending <= 1'b0;
						case (rxCode.code)
							CODE_LSHIFT: shiftL <= !breakPending;
							CODE_RSHIFT: shiftR <= !breakPending;
							CODE_CTRL: begin
								if (extendPending) begin
									ctrlR <= !breakPending;
								end else begin
									ctrlL <= !breakPending;
								end
							end
							CODE_CAPS: begin
								if (!breakPending) begin
									capsOn <= !capsOn;     // Toggles on make only.
								end
							end
							default: begin
								// Modifier state before this byte.
								keyEvent.code <= rxCode.code;
								keyEvent.extended <= extendPending;
								keyEvent.shift <= shiftL || shiftR;
								keyEvent.ctrl <= ctrlL || ctrlR;
								keyEvent.caps <= capsOn;
								keyEvent.valid <= !breakPending;  // No event on release.
							end
						endcase
					end
				endcase
			end
		end
	end

endmodule
